// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_console
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
src/console_pkg.sv
src/bus_pkg.sv
src/console_ram.sv
src/bus_arbiter.sv
src/block_scanner.sv
src/console_sequencer.sv
src/console_top.sv
verif/tb_console.sv

// ==== src/block_scanner.sv ====
// ================================================
// Block scanner
// Copies one 8-byte block from the console RAM to
// the afpga image window, one bus request per byte.
// Pulses done after the last byte is granted
// ================================================
`timescale 1ns/1ps

module block_scanner
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_start_scan,
	input  bus_pkg::ram_addr_t   i_base_addr,
	input  bus_pkg::afpga_data_t i_ram_rdata,
	input  logic                 i_bus_gnt,
	output bus_pkg::ram_addr_t   o_ram_addr,
	output logic                 o_bus_req,
	output bus_pkg::afpga_addr_t o_bus_addr,
	output bus_pkg::afpga_data_t o_bus_wdata,
	output logic                 o_done_scan
);

	localparam int CNT_W = $clog2(console_pkg::BLOCK_BYTES);

	logic             busy;
	logic [CNT_W-1:0] byte_cnt;
	logic             last_byte;
	logic             gnt_taken;

	assign last_byte = (byte_cnt == CNT_W'(console_pkg::BLOCK_BYTES - 1));
	assign gnt_taken = busy & o_bus_req & i_bus_gnt;

	// RAM address is held while requesting, so read data stays put
	assign o_bus_wdata = i_ram_rdata;

	// ================================================
	// Control
	// ================================================
	// busy with no request is the read cycle of a byte
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy        <= 1'b0;
			byte_cnt    <= '0;
			o_bus_req   <= 1'b0;
			o_done_scan <= 1'b0;
		end
		else
		begin
			o_done_scan <= 1'b0;
			if (!busy)
			begin
				if (i_start_scan)
				begin
					busy     <= 1'b1;
					byte_cnt <= '0;
				end
			end
			else if (!o_bus_req)
				o_bus_req <= 1'b1;
			else if (i_bus_gnt)
			begin
				o_bus_req <= 1'b0;
				if (last_byte)
				begin
					busy        <= 1'b0;
					o_done_scan <= 1'b1;
				end
				else
					byte_cnt <= byte_cnt + CNT_W'(1);
			end
		end
	end

	// Read address and bus address
	always_ff @(posedge clk)
	begin
		if (!busy && i_start_scan)
			o_ram_addr <= i_base_addr;
		else if (gnt_taken)
			o_ram_addr <= o_ram_addr + bus_pkg::ram_addr_t'(1);
		// Image window mirrors RAM byte for byte
		if (busy && !o_bus_req)
			o_bus_addr <= bus_pkg::IMAGE_BASE + bus_pkg::afpga_addr_t'(o_ram_addr);
	end

endmodule

// ==== src/bus_arbiter.sv ====
// ================================================
// afpga write arbiter
// Fixed priority with the lowest index first.
// Grant is combinational and the winning write is
// registered onto the bus as a one-cycle strobe
// ================================================
`timescale 1ns/1ps

module bus_arbiter
(
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                 [bus_pkg::NUM_REQ-1:0]  i_req,
	input  bus_pkg::afpga_addr_t [bus_pkg::NUM_REQ-1:0]  i_addr,
	input  bus_pkg::afpga_data_t [bus_pkg::NUM_REQ-1:0]  i_wdata,
	output logic                 [bus_pkg::NUM_REQ-1:0]  o_gnt,
	output logic                                         o_afpga_wren,
	output bus_pkg::afpga_addr_t                         o_afpga_addr,
	output bus_pkg::afpga_data_t                         o_afpga_wdata
);

	// Sequencer beats scanner
	always_comb
	begin
		o_gnt = '0;
		if (i_req[bus_pkg::REQ_SEQ])
			o_gnt[bus_pkg::REQ_SEQ] = 1'b1;
		else if (i_req[bus_pkg::REQ_SCAN])
			o_gnt[bus_pkg::REQ_SCAN] = 1'b1;
	end

	// Write strobe
	always_ff @(posedge clk)
	begin
		if (rst)
			o_afpga_wren <= 1'b0;
		else
			o_afpga_wren <= |o_gnt;
	end

	// Winning payload
	always_ff @(posedge clk)
	begin
		if (o_gnt[bus_pkg::REQ_SEQ])
		begin
			o_afpga_addr  <= i_addr[bus_pkg::REQ_SEQ];
			o_afpga_wdata <= i_wdata[bus_pkg::REQ_SEQ];
		end
		else if (o_gnt[bus_pkg::REQ_SCAN])
		begin
			o_afpga_addr  <= i_addr[bus_pkg::REQ_SCAN];
			o_afpga_wdata <= i_wdata[bus_pkg::REQ_SCAN];
		end
	end

endmodule

// ==== src/bus_pkg.sv ====
// ================================================
// afpga bus and console RAM definitions
// Widths, the image window address and the
// arbiter requester order
// ================================================
package bus_pkg;

	localparam int AFPGA_ADDR_W = 23;
	localparam int AFPGA_DATA_W = 8;
	localparam int RAM_ADDR_W   = 12;

	// RAM byte 0 appears here on the bus
	localparam logic [AFPGA_ADDR_W-1:0] IMAGE_BASE = 23'h00_1000;

	typedef logic [AFPGA_ADDR_W-1:0] afpga_addr_t;
	typedef logic [AFPGA_DATA_W-1:0] afpga_data_t;
	typedef logic [RAM_ADDR_W-1:0]   ram_addr_t;

	// Lower index wins
	localparam int REQ_SEQ  = 0;
	localparam int REQ_SCAN = 1;
	localparam int NUM_REQ  = 2;

endpackage

// ==== src/console_pkg.sv ====
// ================================================
// Console scan definitions
// Descriptor field positions, block geometry, the
// status code and the sequencer state encoding.
// Referenced by scoped name from the sequencer, the
// scanner and the testbench
// ================================================
package console_pkg;

	// Descriptor layout
	localparam int PAR_W    = 64;
	localparam int LEN_LSB  = 0;
	localparam int LEN_MSB  = 15;
	localparam int BASE_LSB = 32;
	localparam int BASE_MSB = 47;

	// Base word moves by one block per scan
	localparam int BLOCK_BYTES      = 8;
	localparam int IN_HEADER_BLOCKS = 16;

	// Status byte posted when the input phase ends
	localparam int STATUS_ADDR    = 0;
	localparam int STATUS_IN_DONE = 3;

	// One-hot sequencer states
	typedef enum logic [7:0] {
		ST_IDLE     = 8'b0000_0001,
		ST_IN_CHK   = 8'b0000_0010,
		ST_IN_SCAN  = 8'b0000_0100,
		ST_STAT     = 8'b0000_1000,
		ST_OUT_CHK  = 8'b0001_0000,
		ST_OUT_SCAN = 8'b0010_0000,
		ST_VAR_CHK  = 8'b0100_0000,
		ST_VAR_SCAN = 8'b1000_0000
	} seq_state_t;

endpackage

// ==== src/console_ram.sv ====
// ================================================
// 4096 x 8 console RAM
// Host writes through one port, the scanner reads
// through the other with one cycle of latency
// ================================================
`timescale 1ns/1ps

module console_ram
(
	input  logic                 clk,
	input  logic                 i_wren,
	input  bus_pkg::ram_addr_t   i_waddr,
	input  bus_pkg::afpga_data_t i_wdata,
	input  bus_pkg::ram_addr_t   i_raddr,
	output bus_pkg::afpga_data_t o_rdata
);

	bus_pkg::afpga_data_t mem [2**bus_pkg::RAM_ADDR_W];

	// Host write port
	always_ff @(posedge clk)
	begin
		if (i_wren)
			mem[i_waddr] <= i_wdata;
	end

	// Registered read returns old data on a collision
	always_ff @(posedge clk)
	begin
		o_rdata <= mem[i_raddr];
	end

endmodule

// ==== src/console_sequencer.sv ====
// ================================================
// Console phase sequencer
// Latches descriptors on i_ini_ok, then on enable
// rising edges runs the input phase (plus status
// write) or the output and variable phases, one
// block scan at a time
// ================================================
`timescale 1ns/1ps

module console_sequencer
(
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   i_con_in_en,
	input  logic                                   i_con_out_en,
	input  logic                                   i_ini_ok,
	input  logic [console_pkg::PAR_W-1:0]          i_con_in_par,
	input  logic [console_pkg::PAR_W-1:0]          i_con_out_par,
	input  logic [console_pkg::PAR_W-1:0]          i_con_var_par,
	input  logic                                   i_done_scan,
	input  logic                                   i_stat_gnt,
	output logic                                   o_start_scan,
	output bus_pkg::ram_addr_t                     o_base_addr,
	output logic                                   o_stat_req,
	output bus_pkg::afpga_addr_t                   o_stat_addr,
	output bus_pkg::afpga_data_t                   o_stat_wdata
);

	// ================================================
	// Descriptor fields and counters
	// ================================================
	logic [console_pkg::LEN_MSB-console_pkg::LEN_LSB:0]   len_in, len_out, len_var;
	logic [console_pkg::BASE_MSB-console_pkg::BASE_LSB:0] ba_in, ba_out, ba_var;

	// One bit wider than a length so length plus header never wraps
	logic [16:0]               blk_cnt;
	logic [16:0]               in_blocks;
	console_pkg::seq_state_t   state;

	logic in_en_d1, in_en_d2;
	logic out_en_d1, out_en_d2;
	logic in_en_pos, out_en_pos;

	// Status write is fixed
	assign o_stat_addr  = bus_pkg::afpga_addr_t'(console_pkg::STATUS_ADDR);
	assign o_stat_wdata = bus_pkg::afpga_data_t'(console_pkg::STATUS_IN_DONE);

	// Input phase keeps the header blocks on top of its length
	assign in_blocks = {1'b0, len_in} + 17'(console_pkg::IN_HEADER_BLOCKS);

	// Descriptor latch
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			len_in  <= '0;
			len_out <= '0;
			len_var <= '0;
			ba_in   <= '0;
			ba_out  <= '0;
			ba_var  <= '0;
		end
		else if (i_ini_ok)
		begin
			len_in  <= i_con_in_par[console_pkg::LEN_MSB:console_pkg::LEN_LSB];
			len_out <= i_con_out_par[console_pkg::LEN_MSB:console_pkg::LEN_LSB];
			len_var <= i_con_var_par[console_pkg::LEN_MSB:console_pkg::LEN_LSB];
			ba_in   <= i_con_in_par[console_pkg::BASE_MSB:console_pkg::BASE_LSB];
			ba_out  <= i_con_out_par[console_pkg::BASE_MSB:console_pkg::BASE_LSB];
			ba_var  <= i_con_var_par[console_pkg::BASE_MSB:console_pkg::BASE_LSB];
		end
	end

	// Two-flop edge detect on both enables
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_en_d1  <= 1'b0;
			in_en_d2  <= 1'b0;
			out_en_d1 <= 1'b0;
			out_en_d2 <= 1'b0;
		end
		else
		begin
			in_en_d1  <= i_con_in_en;
			in_en_d2  <= in_en_d1;
			out_en_d1 <= i_con_out_en;
			out_en_d2 <= out_en_d1;
		end
	end

	assign in_en_pos  = in_en_d1 & ~in_en_d2;
	assign out_en_pos = out_en_d1 & ~out_en_d2;

	// ================================================
	// Phase FSM
	// ================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state        <= console_pkg::ST_IDLE;
			o_start_scan <= 1'b0;
			o_stat_req   <= 1'b0;
			o_base_addr  <= '0;
			blk_cnt      <= '0;
		end
		else
		begin
			// Start is a single-cycle strobe
			o_start_scan <= 1'b0;
			case (state)
				console_pkg::ST_IDLE:
				begin
					if (in_en_pos)
					begin
						state       <= console_pkg::ST_IN_CHK;
						o_base_addr <= ba_in[15 -: bus_pkg::RAM_ADDR_W];
						blk_cnt     <= '0;
					end
				end
				console_pkg::ST_IN_CHK:
				begin
					// Dropping the enable ends the phase early
					if (i_con_in_en && blk_cnt < in_blocks)
					begin
						o_start_scan <= 1'b1;
						state        <= console_pkg::ST_IN_SCAN;
					end
					else
					begin
						o_stat_req <= 1'b1;
						state      <= console_pkg::ST_STAT;
					end
				end
				console_pkg::ST_IN_SCAN:
				begin
					if (i_done_scan)
					begin
						o_base_addr <= o_base_addr + bus_pkg::ram_addr_t'(console_pkg::BLOCK_BYTES);
						blk_cnt     <= blk_cnt + 17'd1;
						state       <= console_pkg::ST_IN_CHK;
					end
				end
				console_pkg::ST_STAT:
				begin
					// Hold status request until granted, then wait for output enable
					if (o_stat_req)
					begin
						if (i_stat_gnt)
							o_stat_req <= 1'b0;
					end
					else if (out_en_pos)
					begin
						state       <= console_pkg::ST_OUT_CHK;
						o_base_addr <= ba_out[15 -: bus_pkg::RAM_ADDR_W];
						blk_cnt     <= '0;
					end
				end
				console_pkg::ST_OUT_CHK:
				begin
					if (!i_con_out_en)
						state <= console_pkg::ST_IDLE;
					else if (blk_cnt < {1'b0, len_out})
					begin
						o_start_scan <= 1'b1;
						state        <= console_pkg::ST_OUT_SCAN;
					end
					else
					begin
						state       <= console_pkg::ST_VAR_CHK;
						o_base_addr <= ba_var[15 -: bus_pkg::RAM_ADDR_W];
						blk_cnt     <= '0;
					end
				end
				console_pkg::ST_OUT_SCAN:
				begin
					if (i_done_scan)
					begin
						o_base_addr <= o_base_addr + bus_pkg::ram_addr_t'(console_pkg::BLOCK_BYTES);
						blk_cnt     <= blk_cnt + 17'd1;
						state       <= console_pkg::ST_OUT_CHK;
					end
				end
				console_pkg::ST_VAR_CHK:
				begin
					if (i_con_out_en && blk_cnt < {1'b0, len_var})
					begin
						o_start_scan <= 1'b1;
						state        <= console_pkg::ST_VAR_SCAN;
					end
					else
						state <= console_pkg::ST_IDLE;
				end
				console_pkg::ST_VAR_SCAN:
				begin
					if (i_done_scan)
					begin
						o_base_addr <= o_base_addr + bus_pkg::ram_addr_t'(console_pkg::BLOCK_BYTES);
						blk_cnt     <= blk_cnt + 17'd1;
						state       <= console_pkg::ST_VAR_CHK;
					end
				end
				default:
					state <= console_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

// ==== src/console_top.sv ====
// ================================================
// Console scan controller top
// Sequencer, block scanner, console RAM and the
// afpga write arbiter. Host loads the RAM and the
// descriptors, then toggles the console enables
// ================================================
`timescale 1ns/1ps

module console_top
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_ini_ok,
	input  logic [console_pkg::PAR_W-1:0] i_con_in_par,
	input  logic [console_pkg::PAR_W-1:0] i_con_out_par,
	input  logic [console_pkg::PAR_W-1:0] i_con_var_par,
	input  logic                          i_con_in_en,
	input  logic                          i_con_out_en,
	input  logic                          i_ram_wren,
	input  bus_pkg::ram_addr_t            i_ram_addr,
	input  bus_pkg::afpga_data_t          i_ram_wdata,
	output logic                          o_afpga_wren,
	output bus_pkg::afpga_addr_t          o_afpga_addr,
	output bus_pkg::afpga_data_t          o_afpga_wdata
);

	// Sequencer to scanner
	logic                 start_scan;
	logic                 done_scan;
	bus_pkg::ram_addr_t   base_addr;

	// Scanner to RAM
	bus_pkg::ram_addr_t   ram_raddr;
	bus_pkg::afpga_data_t ram_rdata;

	// Requesters
	logic                 seq_req, scan_req;
	bus_pkg::afpga_addr_t seq_addr, scan_addr;
	bus_pkg::afpga_data_t seq_wdata, scan_wdata;

	// Arbiter side indexed by priority
	logic                 [bus_pkg::NUM_REQ-1:0] arb_req;
	logic                 [bus_pkg::NUM_REQ-1:0] arb_gnt;
	bus_pkg::afpga_addr_t [bus_pkg::NUM_REQ-1:0] arb_addr;
	bus_pkg::afpga_data_t [bus_pkg::NUM_REQ-1:0] arb_wdata;

	assign arb_req[bus_pkg::REQ_SEQ]    = seq_req;
	assign arb_addr[bus_pkg::REQ_SEQ]   = seq_addr;
	assign arb_wdata[bus_pkg::REQ_SEQ]  = seq_wdata;
	assign arb_req[bus_pkg::REQ_SCAN]   = scan_req;
	assign arb_addr[bus_pkg::REQ_SCAN]  = scan_addr;
	assign arb_wdata[bus_pkg::REQ_SCAN] = scan_wdata;

	console_sequencer u_seq
	(
		.clk           (clk),
		.rst           (rst),
		.i_con_in_en   (i_con_in_en),
		.i_con_out_en  (i_con_out_en),
		.i_ini_ok      (i_ini_ok),
		.i_con_in_par  (i_con_in_par),
		.i_con_out_par (i_con_out_par),
		.i_con_var_par (i_con_var_par),
		.i_done_scan   (done_scan),
		.i_stat_gnt    (arb_gnt[bus_pkg::REQ_SEQ]),
		.o_start_scan  (start_scan),
		.o_base_addr   (base_addr),
		.o_stat_req    (seq_req),
		.o_stat_addr   (seq_addr),
		.o_stat_wdata  (seq_wdata)
	);

	block_scanner u_scan
	(
		.clk          (clk),
		.rst          (rst),
		.i_start_scan (start_scan),
		.i_base_addr  (base_addr),
		.i_ram_rdata  (ram_rdata),
		.i_bus_gnt    (arb_gnt[bus_pkg::REQ_SCAN]),
		.o_ram_addr   (ram_raddr),
		.o_bus_req    (scan_req),
		.o_bus_addr   (scan_addr),
		.o_bus_wdata  (scan_wdata),
		.o_done_scan  (done_scan)
	);

	console_ram u_ram
	(
		.clk     (clk),
		.i_wren  (i_ram_wren),
		.i_waddr (i_ram_addr),
		.i_wdata (i_ram_wdata),
		.i_raddr (ram_raddr),
		.o_rdata (ram_rdata)
	);

	bus_arbiter u_arb
	(
		.clk           (clk),
		.rst           (rst),
		.i_req         (arb_req),
		.i_addr        (arb_addr),
		.i_wdata       (arb_wdata),
		.o_gnt         (arb_gnt),
		.o_afpga_wren  (o_afpga_wren),
		.o_afpga_addr  (o_afpga_addr),
		.o_afpga_wdata (o_afpga_wdata)
	);

endmodule

// ==== verif/tb_console.sv ====
// ==================================================
// Testbench for the console scan controller
// Fills the console RAM from an LFSR, drives the
// descriptors and the console enables, and checks
// every afpga write against a model of the scans.
// Built and run through files.f and the Makefile
// ==================================================
`timescale 1ns/1ps

module tb_console;

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 16;
	localparam int RAM_BYTES  = 2**bus_pkg::RAM_ADDR_W;
	localparam int SETTLE     = 60;
	localparam int BLK        = console_pkg::BLOCK_BYTES;
	localparam int HDR        = console_pkg::IN_HEADER_BLOCKS;

	// Region lengths in blocks and base fields as loaded
	localparam int          LEN_IN_A  = 2;
	localparam int          LEN_OUT   = 3;
	localparam int          LEN_VAR   = 1;
	localparam int          LEN_IN_B  = 5;
	localparam logic [15:0] IN_BASE_A = 16'h0400;
	localparam logic [15:0] OUT_BASE  = 16'h2000;
	localparam logic [15:0] VAR_BASE  = 16'h8000;
	localparam logic [15:0] IN_BASE_B = 16'h1230;
	localparam int          ABORT_AT  = 20;

	// Watchdog budget from the byte count of all tests
	localparam int IN_A_BYTES   = (LEN_IN_A + HDR) * BLK + 1;
	localparam int IN_B_BYTES   = (LEN_IN_B + HDR) * BLK + 1;
	localparam int TOTAL_BYTES  = 2 * IN_A_BYTES + (LEN_OUT + LEN_VAR) * BLK + BLK + IN_B_BYTES;
	localparam int WATCH_CYCLES = RST_CYCLES + 20 + RAM_BYTES + TOTAL_BYTES * 10
		+ 8 * SETTLE + 2000;

	logic                          clk;
	logic                          rst;
	logic                          i_ini_ok;
	logic [console_pkg::PAR_W-1:0] i_con_in_par;
	logic [console_pkg::PAR_W-1:0] i_con_out_par;
	logic [console_pkg::PAR_W-1:0] i_con_var_par;
	logic                          i_con_in_en;
	logic                          i_con_out_en;
	logic                          i_ram_wren;
	bus_pkg::ram_addr_t            i_ram_addr;
	bus_pkg::afpga_data_t          i_ram_wdata;
	logic                          o_afpga_wren;
	bus_pkg::afpga_addr_t          o_afpga_addr;
	bus_pkg::afpga_data_t          o_afpga_wdata;

	// RAM mirror and LFSR state
	bus_pkg::afpga_data_t ram_model [RAM_BYTES];
	logic [15:0]          lfsr_state = 16'd22;

	// Observed and expected writes
	bus_pkg::afpga_addr_t obs_addr [$];
	bus_pkg::afpga_data_t obs_data [$];
	bus_pkg::afpga_addr_t exp_addr [$];
	bus_pkg::afpga_data_t exp_data [$];

	console_top UUT
	(
		.clk           (clk),
		.rst           (rst),
		.i_ini_ok      (i_ini_ok),
		.i_con_in_par  (i_con_in_par),
		.i_con_out_par (i_con_out_par),
		.i_con_var_par (i_con_var_par),
		.i_con_in_en   (i_con_in_en),
		.i_con_out_en  (i_con_out_en),
		.i_ram_wren    (i_ram_wren),
		.i_ram_addr    (i_ram_addr),
		.i_ram_wdata   (i_ram_wdata),
		.o_afpga_wren  (o_afpga_wren),
		.o_afpga_addr  (o_afpga_addr),
		.o_afpga_wdata (o_afpga_wdata)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Bus monitor samples away from the rising edge
	always @(negedge clk)
	begin
		if (o_afpga_wren === 1'b1)
		begin
			obs_addr.push_back(o_afpga_addr);
			obs_data.push_back(o_afpga_wdata);
		end
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	function automatic logic [console_pkg::PAR_W-1:0] make_par(input logic [15:0] base,
		input logic [15:0] len);
		logic [console_pkg::PAR_W-1:0] p;
		p = '0;
		p[console_pkg::BASE_MSB:console_pkg::BASE_LSB] = base;
		p[console_pkg::LEN_MSB:console_pkg::LEN_LSB]   = len;
		return p;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_addr(input string test, input bus_pkg::afpga_addr_t exp,
		input bus_pkg::afpga_addr_t act);
		if (act !== exp)
			stop_on_error($sformatf("[FAIL] %s: expected addr 0x%06h, actual 0x%06h",
				test, exp, act));
	endtask

	task automatic check_data(input string test, input bus_pkg::afpga_data_t exp,
		input bus_pkg::afpga_data_t act);
		if (act !== exp)
			stop_on_error($sformatf("[FAIL] %s: expected data 0x%02h, actual 0x%02h",
				test, exp, act));
	endtask

	task automatic check_count(input string test, input int exp, input int act);
		if (act != exp)
			stop_on_error($sformatf("[FAIL] %s: expected count %0d, actual %0d", test, exp, act));
	endtask

	// Host fill with 8 LFSR bits per byte
	task automatic load_ram();
		bus_pkg::afpga_data_t b;
		for (int a = 0; a < RAM_BYTES; a++)
		begin
			b = '0;
			for (int i = 0; i < 8; i++)
			begin
				b          = {b[6:0], lfsr_state[0]};
				lfsr_state = lfsr_next(lfsr_state);
			end
			ram_model[a] = b;
			tick();
			i_ram_wren  = 1'b1;
			i_ram_addr  = bus_pkg::ram_addr_t'(a);
			i_ram_wdata = b;
		end
		tick();
		i_ram_wren = 1'b0;
	endtask

	task automatic load_descriptors(input logic [15:0] in_base, input int in_len,
		input logic [15:0] out_base, input int out_len,
		input logic [15:0] var_base, input int var_len);
		i_con_in_par  = make_par(in_base, 16'(in_len));
		i_con_out_par = make_par(out_base, 16'(out_len));
		i_con_var_par = make_par(var_base, 16'(var_len));
		tick();
		i_ini_ok = 1'b1;
		tick();
		i_ini_ok = 1'b0;
	endtask

	// Expected copies of one region starting at RAM word base bits [15:4]
	task automatic add_region(input logic [15:0] base_field, input int blocks);
		bus_pkg::ram_addr_t word;
		bus_pkg::ram_addr_t ra;
		word = base_field[15:4];
		for (int k = 0; k < blocks; k++)
		begin
			for (int j = 0; j < BLK; j++)
			begin
				ra = word + bus_pkg::ram_addr_t'(k * BLK + j);
				exp_addr.push_back(bus_pkg::IMAGE_BASE + bus_pkg::afpga_addr_t'(ra));
				exp_data.push_back(ram_model[ra]);
			end
		end
	endtask

	task automatic add_status();
		exp_addr.push_back(bus_pkg::afpga_addr_t'(console_pkg::STATUS_ADDR));
		exp_data.push_back(bus_pkg::afpga_data_t'(console_pkg::STATUS_IN_DONE));
	endtask

	task automatic clear_queues();
		obs_addr.delete();
		obs_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic wait_writes(input int n);
		while (obs_addr.size() < n)
			tick();
	endtask

	task automatic compare_prefix(input string test, input int n);
		for (int i = 0; i < n; i++)
		begin
			check_addr($sformatf("%s write %0d", test, i), exp_addr[i], obs_addr[i]);
			check_data($sformatf("%s write %0d", test, i), exp_data[i], obs_data[i]);
		end
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic test_reset();
		repeat (20) tick();
		check_count("reset", 0, obs_addr.size());
	endtask

	task automatic test_input_phase();
		clear_queues();
		add_region(IN_BASE_A, LEN_IN_A + HDR);
		add_status();
		tick();
		i_con_in_en = 1'b1;
		wait_writes(exp_addr.size());
		repeat (SETTLE) tick();
		check_count("input phase", exp_addr.size(), obs_addr.size());
		compare_prefix("input phase", exp_addr.size());
		i_con_in_en = 1'b0;
	endtask

	// Output region then variable region with the enable held
	task automatic test_output_phases();
		clear_queues();
		add_region(OUT_BASE, LEN_OUT);
		add_region(VAR_BASE, LEN_VAR);
		tick();
		i_con_out_en = 1'b1;
		wait_writes(exp_addr.size());
		repeat (SETTLE) tick();
		check_count("output phases", exp_addr.size(), obs_addr.size());
		compare_prefix("output phases", exp_addr.size());
		i_con_out_en = 1'b0;
	endtask

	task automatic test_input_abort();
		int n_copy;
		clear_queues();
		add_region(IN_BASE_A, LEN_IN_A + HDR);
		tick();
		i_con_in_en = 1'b1;
		wait_writes(ABORT_AT);
		i_con_in_en = 1'b0;
		// Current block finishes before the status byte
		while (obs_addr.size() == 0 ||
			obs_addr[$] !== bus_pkg::afpga_addr_t'(console_pkg::STATUS_ADDR))
			tick();
		repeat (SETTLE) tick();
		n_copy = obs_addr.size() - 1;
		if (n_copy >= exp_addr.size())
			stop_on_error("Input abort did not end the input phase before its last block");
		check_count("input abort whole blocks", (n_copy / BLK) * BLK, n_copy);
		compare_prefix("input abort", n_copy);
		check_addr("input abort status", bus_pkg::afpga_addr_t'(console_pkg::STATUS_ADDR),
			obs_addr[n_copy]);
		check_data("input abort status", bus_pkg::afpga_data_t'(console_pkg::STATUS_IN_DONE),
			obs_data[n_copy]);
	endtask

	task automatic test_output_gate();
		int n;
		clear_queues();
		add_region(OUT_BASE, LEN_OUT);
		tick();
		i_con_out_en = 1'b1;
		tick();
		i_con_out_en = 1'b0;
		repeat (2 * SETTLE) tick();
		n = obs_addr.size();
		if (n > BLK)
			stop_on_error("Output gate let more than one block through after a short enable");
		check_count("output gate whole blocks", (n / BLK) * BLK, n);
		compare_prefix("output gate", n);
	endtask

	// Sequencer must be idle again for this phase to start
	task automatic test_reload();
		clear_queues();
		load_descriptors(IN_BASE_B, LEN_IN_B, OUT_BASE, LEN_OUT, VAR_BASE, LEN_VAR);
		add_region(IN_BASE_B, LEN_IN_B + HDR);
		add_status();
		tick();
		i_con_in_en = 1'b1;
		wait_writes(exp_addr.size());
		repeat (SETTLE) tick();
		check_count("descriptor reload", exp_addr.size(), obs_addr.size());
		compare_prefix("descriptor reload", exp_addr.size());
		i_con_in_en = 1'b0;
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================
	initial
	begin
		rst           = 1'b1;
		i_ini_ok      = 1'b0;
		i_con_in_par  = '0;
		i_con_out_par = '0;
		i_con_var_par = '0;
		i_con_in_en   = 1'b0;
		i_con_out_en  = 1'b0;
		i_ram_wren    = 1'b0;
		i_ram_addr    = '0;
		i_ram_wdata   = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset();
		load_ram();
		load_descriptors(IN_BASE_A, LEN_IN_A, OUT_BASE, LEN_OUT, VAR_BASE, LEN_VAR);
		test_input_phase();
		test_output_phases();
		test_input_abort();
		test_output_gate();
		test_reload();
		$display("Test completed successfully");
		$finish;
	end

	initial
	begin
		#(WATCH_CYCLES * CLK_PERIOD);
		stop_on_error("Timeout: the DUT stopped producing the expected afpga writes");
	end

endmodule
